/* rtl/axil_bridge_consts.svh */
// Bus widths, tag FIFO depth and AXI codes for the read bridge
// WRAP has no code of its own and is handled as INCR
// Data width is fixed at 32 bits, so ARSIZE above 2 is not supported

`ifndef AXIL_BRIDGE_CONSTS_SVH
`define AXIL_BRIDGE_CONSTS_SVH

`define AXB_ID_W        2
`define AXB_ADDR_W      12
`define AXB_DATA_W      32
`define AXB_LEN_W       8

// Four bursts outstanding
`define AXB_LG_FIFO     2

`define AXB_BURST_FIXED 2'b00
`define AXB_BURST_INCR  2'b01

`define AXB_RESP_OKAY   2'b00
`define AXB_RESP_SLVERR 2'b10

`endif

/* rtl/axil_bridge_pkg.sv */
// Vector types shared by the read bridge
// Widths come from the constants header

`include "axil_bridge_consts.svh"

package axil_bridge_pkg;

	typedef logic [`AXB_ID_W-1:0]   axi_id_t;
	typedef logic [`AXB_ADDR_W-1:0] axi_addr_t;
	typedef logic [`AXB_DATA_W-1:0] axi_data_t;

	// Beat count minus one
	typedef logic [`AXB_LEN_W-1:0]  axi_len_t;

	// Log2 of bytes per beat
	typedef logic [2:0]             axi_size_t;
	typedef logic [1:0]             axi_burst_t;
	typedef logic [1:0]             axi_resp_t;

	typedef enum logic {
		SEQ_IDLE,
		SEQ_ISSUE
	} seq_state_t;

endpackage

/* rtl/burst_req_if.sv */
// One accepted AXI read burst request, skid buffer to sequencer
// Transfers when valid and ready are both high; valid holds until then

`timescale 1ns/1ps

interface burst_req_if import axil_bridge_pkg::*; ();

	logic       valid;
	logic       ready;
	axi_id_t    id;
	axi_addr_t  addr;
	axi_len_t   len;
	axi_size_t  size;
	axi_burst_t burst;

	// Request producer
	modport source (
		output valid, id, addr, len, size, burst,
		input  ready
	);

	// Request consumer
	modport sink (
		input  valid, id, addr, len, size, burst,
		output ready
	);

endinterface

/* rtl/skid_buffer.sv */
// Valid/ready skid buffer, pass-through path plus one holding register
// o_ready comes straight from a flop, so the upstream ready path is cut
// o_valid follows i_valid combinationally while the buffer is empty

`timescale 1ns/1ps

module skid_buffer #(
	parameter int DATA_W = 8
) (
	input  logic              S_AXI_ACLK,
	input  logic              S_AXI_ARESETN,
	// Upstream side
	input  logic              i_valid,
	output logic              o_ready,
	input  logic [DATA_W-1:0] i_data,
	// Downstream side
	output logic              o_valid,
	input  logic              i_ready,
	output logic [DATA_W-1:0] o_data
);

	logic              hold_valid;
	logic [DATA_W-1:0] hold_data;

	////////////////////
	// Holding register
	////////////////////

	// Fill when a word arrives and the output stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			hold_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			hold_valid <= 1'b1;
		else if (i_ready)
			hold_valid <= 1'b0;
	end

	// Tracks the input while empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			hold_data <= i_data;
	end

	////////////////////
	// Outputs
	////////////////////

	assign o_ready = !hold_valid;

	// Held word goes first
	assign o_valid = i_valid || hold_valid;
	assign o_data  = hold_valid ? hold_data : i_data;

endmodule

/* rtl/burst_addr_seq.sv */
// Splits an AXI read burst into single AXI-Lite read addresses
// FIXED repeats the start address; INCR and WRAP step by the beat size
// A burst is accepted only when its tag fits in the tag FIFO

`timescale 1ns/1ps

`include "axil_bridge_consts.svh"

module burst_addr_seq import axil_bridge_pkg::*; (
	input  logic      S_AXI_ACLK,
	input  logic      S_AXI_ARESETN,
	burst_req_if.sink req,
	// AXI-Lite read address
	output axi_addr_t o_araddr,
	output logic      o_arvalid,
	input  logic      i_arready,
	// Tag FIFO write side
	output logic      o_tag_push,
	output axi_id_t   o_tag_id,
	output axi_len_t  o_tag_len,
	input  logic      i_tag_full
);

	seq_state_t state;
	axi_addr_t  cur_addr;
	axi_addr_t  next_addr;
	axi_addr_t  beat_step;
	axi_len_t   beats_left;
	axi_size_t  cur_size;
	axi_burst_t cur_burst;
	logic       addr_taken;
	logic       last_taken;
	logic       accept;

	assign o_arvalid  = (state == SEQ_ISSUE);
	assign o_araddr   = cur_addr;
	assign addr_taken = o_arvalid && i_arready;
	assign last_taken = addr_taken && (beats_left == '0);

	// Next burst may start on the cycle the last address goes out
	assign req.ready = ((state == SEQ_IDLE) || last_taken) && !i_tag_full;
	assign accept    = req.valid && req.ready;

	// Record ID and length for the return path
	assign o_tag_push = accept;
	assign o_tag_id   = req.id;
	assign o_tag_len  = req.len;

	////////////////////
	// Next beat address
	////////////////////

	always_comb
	begin
		beat_step = axi_addr_t'(1) << cur_size;
		if (cur_burst == `AXB_BURST_FIXED)
			next_addr = cur_addr;
		else
			next_addr = (cur_addr & ~(beat_step - 1'b1)) + beat_step;
	end

	////////////////////
	// Sequencer FSM
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state      <= SEQ_IDLE;
			beats_left <= '0;
		end
		else if (accept)
		begin
			state      <= SEQ_ISSUE;
			beats_left <= req.len;
		end
		else
		begin
			case (state)
			SEQ_ISSUE:
				if (last_taken)
					state <= SEQ_IDLE;
				else if (addr_taken)
					beats_left <= beats_left - 1'b1;
			default:
				state <= SEQ_IDLE;
			endcase
		end
	end

	// Burst fields, loaded on accept
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (accept)
		begin
			cur_addr  <= req.addr;
			cur_size  <= req.size;
			cur_burst <= req.burst;
		end
		else if (addr_taken)
			cur_addr <= next_addr;
	end

endmodule

/* rtl/burst_tag_fifo.sv */
// Synchronous FIFO of burst ID and length, 2**LG_DEPTH entries
// The oldest entry is shown on the pop outputs while not empty
// Push when full and pop when empty are ignored

`timescale 1ns/1ps

module burst_tag_fifo import axil_bridge_pkg::*; #(
	parameter int LG_DEPTH = 2
) (
	input  logic     S_AXI_ACLK,
	input  logic     S_AXI_ARESETN,
	// Write side
	input  logic     i_push,
	input  axi_id_t  i_push_id,
	input  axi_len_t i_push_len,
	output logic     o_full,
	// Read side
	input  logic     i_pop,
	output axi_id_t  o_pop_id,
	output axi_len_t o_pop_len,
	output logic     o_empty
);

	localparam int DEPTH = 1 << LG_DEPTH;

	axi_id_t           id_mem  [DEPTH];
	axi_len_t          len_mem [DEPTH];
	logic [LG_DEPTH:0] wr_ptr;
	logic [LG_DEPTH:0] rd_ptr;
	logic              do_push;
	logic              do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	// Extra pointer bit tells full from empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (do_push)
		begin
			id_mem[wr_ptr[LG_DEPTH-1:0]]  <= i_push_id;
			len_mem[wr_ptr[LG_DEPTH-1:0]] <= i_push_len;
		end
	end

	assign o_empty   = (wr_ptr == rd_ptr);
	assign o_full    = (wr_ptr[LG_DEPTH] != rd_ptr[LG_DEPTH])
		&& (wr_ptr[LG_DEPTH-1:0] == rd_ptr[LG_DEPTH-1:0]);
	assign o_pop_id  = id_mem[rd_ptr[LG_DEPTH-1:0]];
	assign o_pop_len = len_mem[rd_ptr[LG_DEPTH-1:0]];

endmodule

/* rtl/read_return.sv */
// Rebuilds the AXI R channel from single-beat AXI-Lite responses
// Beats are tagged in issue order with the ID from the tag FIFO
// RRESP is passed through per beat, with no merging across the burst

`timescale 1ns/1ps

module read_return import axil_bridge_pkg::*; (
	input  logic      S_AXI_ACLK,
	input  logic      S_AXI_ARESETN,
	// Single-beat responses from the R skid buffer
	input  logic      i_rvalid,
	output logic      o_rready,
	input  axi_data_t i_rdata,
	input  axi_resp_t i_rresp,
	// Tag FIFO read side
	input  logic      i_tag_empty,
	output logic      o_tag_pop,
	input  axi_id_t   i_tag_id,
	input  axi_len_t  i_tag_len,
	// AXI R channel
	output logic      o_s_rvalid,
	input  logic      i_s_rready,
	output axi_id_t   o_s_rid,
	output axi_data_t o_s_rdata,
	output axi_resp_t o_s_rresp,
	output logic      o_s_rlast
);

	logic     active;
	axi_len_t beats_left;
	axi_len_t cur_left;
	logic     cur_last;
	logic     take;

	// Output slot free, and the burst's tag known
	assign o_rready  = (!o_s_rvalid || i_s_rready) && (active || !i_tag_empty);
	assign take      = i_rvalid && o_rready;

	// First beat of a burst consumes its tag
	assign o_tag_pop = take && !active;
	assign cur_left  = active ? beats_left : i_tag_len;
	assign cur_last  = (cur_left == '0);

	////////////////////
	// Beat counter
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			active     <= 1'b0;
			beats_left <= '0;
		end
		else if (take)
		begin
			active     <= !cur_last;
			beats_left <= cur_left - 1'b1;
		end
	end

	////////////////////
	// R outputs
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_s_rvalid <= 1'b0;
			o_s_rlast  <= 1'b0;
		end
		else if (take)
		begin
			o_s_rvalid <= 1'b1;
			o_s_rlast  <= cur_last;
		end
		else if (i_s_rready)
		begin
			o_s_rvalid <= 1'b0;
			o_s_rlast  <= 1'b0;
		end
	end

	// ID changes only at the first beat of a burst
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_tag_pop)
			o_s_rid <= i_tag_id;
		if (take)
		begin
			o_s_rdata <= i_rdata;
			o_s_rresp <= i_rresp;
		end
	end

endmodule

/* rtl/axi2axil_rd.sv */
// AXI4 to AXI4-Lite read bridge, one AXI-Lite read per burst beat
// FIXED and INCR bursts; WRAP is handled as INCR
// Up to 2**AXB_LG_FIFO bursts may be outstanding
// LOCK, CACHE, PROT and QOS are not taken; ARPROT is not driven

`timescale 1ns/1ps

`include "axil_bridge_consts.svh"

module axi2axil_rd import axil_bridge_pkg::*; (
	input  logic       S_AXI_ACLK,
	input  logic       S_AXI_ARESETN,
	// AXI read address
	input  logic       i_s_arvalid,
	output logic       o_s_arready,
	input  axi_id_t    i_s_arid,
	input  axi_addr_t  i_s_araddr,
	input  axi_len_t   i_s_arlen,
	input  axi_size_t  i_s_arsize,
	input  axi_burst_t i_s_arburst,
	// AXI read data
	output logic       o_s_rvalid,
	input  logic       i_s_rready,
	output axi_id_t    o_s_rid,
	output axi_data_t  o_s_rdata,
	output axi_resp_t  o_s_rresp,
	output logic       o_s_rlast,
	// AXI-Lite read address
	output axi_addr_t  o_m_araddr,
	output logic       o_m_arvalid,
	input  logic       i_m_arready,
	// AXI-Lite read data
	input  logic       i_m_rvalid,
	output logic       o_m_rready,
	input  axi_data_t  i_m_rdata,
	input  axi_resp_t  i_m_rresp
);

	localparam int AR_W = $bits(axi_id_t) + $bits(axi_addr_t) + $bits(axi_len_t)
		+ $bits(axi_size_t) + $bits(axi_burst_t);
	localparam int R_W  = $bits(axi_data_t) + $bits(axi_resp_t);

	logic [AR_W-1:0] ar_skid_data;
	logic            r_skid_valid;
	logic            r_skid_ready;
	axi_data_t       r_skid_rdata;
	axi_resp_t       r_skid_rresp;
	logic            tag_push;
	logic            tag_full;
	logic            tag_pop;
	logic            tag_empty;
	axi_id_t         tag_push_id;
	axi_id_t         tag_pop_id;
	axi_len_t        tag_push_len;
	axi_len_t        tag_pop_len;

	burst_req_if u_req ();

	////////////////////
	// AR path
	////////////////////

	skid_buffer #(.DATA_W(AR_W)) u_ar_skid (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_valid       (i_s_arvalid),
		.o_ready       (o_s_arready),
		.i_data        ({i_s_arid, i_s_araddr, i_s_arlen, i_s_arsize, i_s_arburst}),
		.o_valid       (u_req.valid),
		.i_ready       (u_req.ready),
		.o_data        (ar_skid_data)
	);

	assign {u_req.id, u_req.addr, u_req.len, u_req.size, u_req.burst} = ar_skid_data;

	burst_addr_seq u_seq (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.req           (u_req),
		.o_araddr      (o_m_araddr),
		.o_arvalid     (o_m_arvalid),
		.i_arready     (i_m_arready),
		.o_tag_push    (tag_push),
		.o_tag_id      (tag_push_id),
		.o_tag_len     (tag_push_len),
		.i_tag_full    (tag_full)
	);

	burst_tag_fifo #(.LG_DEPTH(`AXB_LG_FIFO)) u_tag_fifo (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_push        (tag_push),
		.i_push_id     (tag_push_id),
		.i_push_len    (tag_push_len),
		.o_full        (tag_full),
		.i_pop         (tag_pop),
		.o_pop_id      (tag_pop_id),
		.o_pop_len     (tag_pop_len),
		.o_empty       (tag_empty)
	);

	////////////////////
	// R path
	////////////////////

	skid_buffer #(.DATA_W(R_W)) u_r_skid (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_valid       (i_m_rvalid),
		.o_ready       (o_m_rready),
		.i_data        ({i_m_rdata, i_m_rresp}),
		.o_valid       (r_skid_valid),
		.i_ready       (r_skid_ready),
		.o_data        ({r_skid_rdata, r_skid_rresp})
	);

	read_return u_return (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_rvalid      (r_skid_valid),
		.o_rready      (r_skid_ready),
		.i_rdata       (r_skid_rdata),
		.i_rresp       (r_skid_rresp),
		.i_tag_empty   (tag_empty),
		.o_tag_pop     (tag_pop),
		.i_tag_id      (tag_pop_id),
		.i_tag_len     (tag_pop_len),
		.o_s_rvalid    (o_s_rvalid),
		.i_s_rready    (i_s_rready),
		.o_s_rid       (o_s_rid),
		.o_s_rdata     (o_s_rdata),
		.o_s_rresp     (o_s_rresp),
		.o_s_rlast     (o_s_rlast)
	);

endmodule

/* tests/axi2axil_rd_assert.sv */
// Protocol assertions for the read bridge, attached to the top level by bind
// The reset check is the only one active while reset is asserted

`timescale 1ns/1ps

module axi2axil_rd_assert import axil_bridge_pkg::*; (
	input logic      S_AXI_ACLK,
	input logic      S_AXI_ARESETN,
	// AXI R channel
	input logic      i_s_rvalid,
	input logic      i_s_rready,
	input axi_id_t   i_s_rid,
	input axi_data_t i_s_rdata,
	input axi_resp_t i_s_rresp,
	input logic      i_s_rlast,
	// R skid buffer output
	input logic      i_r_skid_valid,
	input logic      i_r_skid_ready,
	input axi_data_t i_r_skid_rdata,
	input axi_resp_t i_r_skid_rresp,
	// AXI-Lite read address
	input logic      i_m_arvalid
);

	int err_count = 0;

	// AXI R beat held until taken
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_s_rvalid && !i_s_rready |=> i_s_rvalid
		&& $stable({i_s_rid, i_s_rdata, i_s_rresp, i_s_rlast}))
	else
	begin
		$error("R channel beat changed or dropped before RREADY");
		err_count++;
	end

	// Same rule at the R skid output
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_r_skid_valid && !i_r_skid_ready |=> i_r_skid_valid
		&& $stable({i_r_skid_rdata, i_r_skid_rresp}))
	else
	begin
		$error("R skid output changed or dropped before ready");
		err_count++;
	end

	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_s_rlast |-> i_s_rvalid)
	else
	begin
		$error("RLAST high without RVALID");
		err_count++;
	end

	// Reset is synchronous so the check lands one clock later
	assert property (@(posedge S_AXI_ACLK) !S_AXI_ARESETN |=> !i_m_arvalid)
	else
	begin
		$error("AXI-Lite ARVALID high during reset");
		err_count++;
	end

endmodule

bind axi2axil_rd axi2axil_rd_assert i_assert (
	.S_AXI_ACLK     (S_AXI_ACLK),
	.S_AXI_ARESETN  (S_AXI_ARESETN),
	.i_s_rvalid     (o_s_rvalid),
	.i_s_rready     (i_s_rready),
	.i_s_rid        (o_s_rid),
	.i_s_rdata      (o_s_rdata),
	.i_s_rresp      (o_s_rresp),
	.i_s_rlast      (o_s_rlast),
	.i_r_skid_valid (r_skid_valid),
	.i_r_skid_ready (r_skid_ready),
	.i_r_skid_rdata (r_skid_rdata),
	.i_r_skid_rresp (r_skid_rresp),
	.i_m_arvalid    (o_m_arvalid)
);

/* tests/axi2axil_rd_tb.sv */
// Testbench for the AXI4 to AXI4-Lite read bridge
// The AXI-Lite side is a model that answers in order after 0 to 3 cycles
// RDATA is a fixed function of the address; bit 11 set gives SLVERR
// Expects the bound assertion module to be compiled with it

`timescale 1ns/1ps

`include "axil_bridge_consts.svh"

module axi2axil_rd_tb import axil_bridge_pkg::*; ();

	// About 130 beats at under 10 cycles each plus a wide margin
	localparam int MAX_CYCLES = 4000;

	logic       clk;
	logic       rst_n;
	logic       i_s_arvalid;
	logic       o_s_arready;
	axi_id_t    i_s_arid;
	axi_addr_t  i_s_araddr;
	axi_len_t   i_s_arlen;
	axi_size_t  i_s_arsize;
	axi_burst_t i_s_arburst;
	logic       o_s_rvalid;
	logic       i_s_rready;
	axi_id_t    o_s_rid;
	axi_data_t  o_s_rdata;
	axi_resp_t  o_s_rresp;
	logic       o_s_rlast;
	axi_addr_t  o_m_araddr;
	logic       o_m_arvalid;
	logic       i_m_arready;
	logic       i_m_rvalid;
	logic       o_m_rready;
	axi_data_t  i_m_rdata;
	axi_resp_t  i_m_rresp;

	integer     seed;
	int         errors;
	int         checks;
	int         test_err0;
	int         cycles;
	int         r_wait;
	logic       slow_resp;
	logic       rready_stall;
	axi_addr_t  lite_q[$];
	axi_addr_t  exp_addr_q[$];
	axi_addr_t  exp_baddr_q[$];
	axi_id_t    exp_id_q[$];
	logic       exp_last_q[$];

	axi2axil_rd i_dut (.S_AXI_ACLK(clk), .S_AXI_ARESETN(rst_n), .*);

	always #10 clk = ~clk;

	////////////////////
	// Reference model
	////////////////////

	// Beat n is the aligned start plus n beats, or the start for FIXED
	function automatic axi_addr_t ref_beat_addr(input axi_addr_t start, input axi_size_t size,
		input axi_burst_t burst, input int n);
		axi_addr_t step;
		step = axi_addr_t'(1 << size);
		if (burst == `AXB_BURST_FIXED || n == 0)
			return start;
		return (start & ~(step - 1'b1)) + axi_addr_t'(n) * step;
	endfunction

	function automatic axi_data_t data_for_addr(input axi_addr_t a);
		return {4'hc, a, 4'h3, ~a};
	endfunction

	function automatic axi_resp_t resp_for_addr(input axi_addr_t a);
		return a[11] ? `AXB_RESP_SLVERR : `AXB_RESP_OKAY;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else
		begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	////////////////////
	// Stimulus tasks
	////////////////////

	// Queue the expected beats, then hold ARVALID until the bridge takes it
	task automatic send_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
		input axi_size_t size, input axi_burst_t burst);
		axi_addr_t a;
		for (int n = 0; n <= len; n++)
		begin
			a = ref_beat_addr(addr, size, burst, n);
			exp_addr_q.push_back(a);
			exp_baddr_q.push_back(a);
			exp_id_q.push_back(id);
			exp_last_q.push_back(n == len);
		end
		i_s_arvalid = 1'b1;
		i_s_arid    = id;
		i_s_araddr  = addr;
		i_s_arlen   = len;
		i_s_arsize  = size;
		i_s_arburst = burst;
		do
			@(posedge clk);
		while (!o_s_arready);
		#2;
		i_s_arvalid = 1'b0;
	endtask

	// Wait for all expected traffic, then report the test
	task automatic end_test(input string name);
		while (exp_id_q.size() != 0 || exp_addr_q.size() != 0)
		begin
			@(posedge clk);
			#2;
		end
		repeat (2)
			@(posedge clk);
		#2;
		$display("Test %s: %0d errors", name, errors - test_err0);
		test_err0 = errors;
	endtask

	////////////////////
	// AXI-Lite model
	////////////////////

	always
	begin : lite_model
		logic      in_reset;
		logic      ar_hs;
		logic      r_hs;
		axi_addr_t a;
		@(posedge clk);
		in_reset = !rst_n;
		ar_hs    = o_m_arvalid && i_m_arready;
		r_hs     = i_m_rvalid && o_m_rready;
		if (ar_hs)
		begin
			assert (exp_addr_q.size() != 0) else
			begin
				$display("AXI-Lite read address issued with no beat expected");
				errors++;
			end
			if (exp_addr_q.size() != 0)
				compare_value("o_m_araddr", o_m_araddr, exp_addr_q.pop_front());
			lite_q.push_back(o_m_araddr);
		end
		#2;
		if (in_reset)
		begin
			i_m_arready = 1'b0;
			i_m_rvalid  = 1'b0;
			i_s_rready  = 1'b0;
			r_wait      = 0;
		end
		else
		begin
			if (r_hs)
				i_m_rvalid = 1'b0;
			if (!i_m_rvalid && lite_q.size() != 0)
			begin
				if (r_wait == 0)
				begin
					a          = lite_q.pop_front();
					i_m_rvalid = 1'b1;
					i_m_rdata  = data_for_addr(a);
					i_m_rresp  = resp_for_addr(a);
					r_wait     = slow_resp ? 3 : ($random(seed) & 3);
				end
				else
					r_wait--;
			end
			i_m_arready = ($random(seed) & 3) != 0;
			i_s_rready  = rready_stall ? (($random(seed) & 1) != 0) : 1'b1;
		end
	end

	// Checks R channel beats in issue order
	always @(posedge clk)
	begin : r_checker
		axi_addr_t a;
		if (rst_n && o_s_rvalid && i_s_rready)
		begin
			assert (exp_id_q.size() != 0) else
			begin
				$display("R channel beat returned with no burst outstanding");
				errors++;
			end
			if (exp_id_q.size() != 0)
			begin
				a = exp_baddr_q.pop_front();
				compare_value("o_s_rid", o_s_rid, exp_id_q.pop_front());
				compare_value("o_s_rdata", o_s_rdata, data_for_addr(a));
				compare_value("o_s_rresp", o_s_rresp, resp_for_addr(a));
				compare_value("o_s_rlast", o_s_rlast, exp_last_q.pop_front());
			end
		end
	end

	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run still busy after %0d cycles, %0d checks, %0d errors",
			MAX_CYCLES, checks, errors);
		$display("CHECKS FAILED");
		$finish;
	end

	////////////////////
	// Test sequence
	////////////////////

	initial
	begin
		seed         = 32'h1089_94d3;
		errors       = 0;
		checks       = 0;
		test_err0    = 0;
		r_wait       = 0;
		slow_resp    = 1'b0;
		rready_stall = 1'b0;
		clk          = 1'b0;
		rst_n        = 1'b0;
		i_s_arvalid  = 1'b0;
		i_s_arid     = '0;
		i_s_araddr   = '0;
		i_s_arlen    = '0;
		i_s_arsize   = '0;
		i_s_arburst  = '0;
		i_s_rready   = 1'b0;
		i_m_arready  = 1'b0;
		i_m_rvalid   = 1'b0;
		i_m_rdata    = '0;
		i_m_rresp    = '0;
		repeat (4)
			@(posedge clk);
		#2;
		rst_n = 1'b1;

		compare_value("o_m_arvalid", o_m_arvalid, 1'b0);
		compare_value("o_s_rvalid", o_s_rvalid, 1'b0);
		compare_value("o_s_arready", o_s_arready, 1'b1);
		end_test("reset state");

		repeat (8)
			send_burst(axi_id_t'($random(seed)), axi_addr_t'($random(seed)), 0, 2,
				`AXB_BURST_INCR);
		end_test("single beats");

		for (int len = 0; len < 8; len++)
			send_burst(axi_id_t'($random(seed)), axi_addr_t'($random(seed)),
				axi_len_t'(len), 2, `AXB_BURST_INCR);
		end_test("incr bursts");

		send_burst(1, 12'h104, 3, 2, `AXB_BURST_FIXED);
		send_burst(2, 12'h8a6, 5, 2, `AXB_BURST_FIXED);
		send_burst(3, 12'h3f0, 0, 2, `AXB_BURST_FIXED);
		send_burst(0, 12'h010, 7, 2, `AXB_BURST_FIXED);
		end_test("fixed bursts");

		// Slow answers keep several bursts in flight
		slow_resp = 1'b1;
		for (int id = 0; id < 4; id++)
			send_burst(axi_id_t'(id), 12'h200 + 12'(id * 12'h420), 3, 2, `AXB_BURST_INCR);
		end_test("outstanding");
		slow_resp = 1'b0;

		rready_stall = 1'b1;
		repeat (12)
			send_burst(axi_id_t'($random(seed)), axi_addr_t'($random(seed)),
				axi_len_t'($random(seed) & 7),
				(($random(seed) & 3) == 3) ? 3'd2 : axi_size_t'(($random(seed) & 3) % 3),
				(($random(seed) & 1) != 0) ? `AXB_BURST_INCR : `AXB_BURST_FIXED);
		end_test("rready stalls");
		rready_stall = 1'b0;

		$display("Summary: %0d checks, %0d check errors, %0d assertion errors",
			checks, errors, i_dut.i_assert.err_count);
		if (errors == 0 && i_dut.i_assert.err_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+rtl
rtl/axil_bridge_pkg.sv
rtl/burst_req_if.sv
rtl/skid_buffer.sv
rtl/burst_addr_seq.sv
rtl/burst_tag_fifo.sv
rtl/read_return.sv
rtl/axi2axil_rd.sv
tests/axi2axil_rd_assert.sv
tests/axi2axil_rd_tb.sv
